//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // machine sizes
    localparam int instr_w    = 16;
    localparam int data_w     = 8;
    localparam int reg_count  = 4;
    localparam int pc_w       = 8;
    localparam int dmem_words = 16;
    localparam int reg_aw     = $clog2(reg_count);
    localparam int dmem_aw    = $clog2(dmem_words);

    // opcode sits in instruction bits 15..12
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADDI  = 4'd1,
        OP_ADD   = 4'd2,
        OP_LOAD  = 4'd3,
        OP_STORE = 4'd4,
        OP_JMP   = 4'd5,
        OP_HALT  = 4'd6
    } opcode_t;

    //////////////////////////////////////////////////////////////////////
    // instruction field access

    function automatic opcode_t op_of(input logic [instr_w-1:0] instr);
        return opcode_t'(instr[15:12]);
    endfunction

    function automatic logic [reg_aw-1:0] rd_of(input logic [instr_w-1:0] instr);
        return instr[11:10];
    endfunction

    function automatic logic [reg_aw-1:0] rs_of(input logic [instr_w-1:0] instr);
        return instr[9:8];
    endfunction

    function automatic logic [data_w-1:0] imm_of(input logic [instr_w-1:0] instr);
        return instr[7:0];
    endfunction

    // data memory word comes from the low imm bits
    function automatic logic [dmem_aw-1:0] dmem_addr_of(input logic [instr_w-1:0] instr);
        return instr[dmem_aw-1:0];
    endfunction

    // ops that end in a register write
    function automatic logic writes_reg(input opcode_t op);
        return op inside {OP_ADD, OP_ADDI, OP_LOAD};
    endfunction

endpackage

`default_nettype wire

//--- src/trace_pkg.sv
`default_nettype none

package trace_pkg;

    // default width of the sequence tag given to each fetched instruction
    localparam int seq_w = 4;

    // cycle stamp width, wraps after 64k cycles
    localparam int stamp_w = 16;

    // default stamp table rows, must cover every tag in flight
    localparam int trace_depth = 8;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
`default_nettype none

module fetch_stage
    import pipe_pkg::*, trace_pkg::*;
#(
    parameter int SEQ_W = seq_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  logic [pc_w-1:0]    jump_target,
    input  logic [instr_w-1:0] imem_data,
    output logic [pc_w-1:0]    imem_addr,
    output logic               f_valid,
    output logic [pc_w-1:0]    f_pc,
    output logic [instr_w-1:0] f_instr,
    output logic               fetch_fire,
    output logic [SEQ_W-1:0]   fetch_seq,
    output logic               halted
);

    logic [pc_w-1:0]  pc;
    logic [SEQ_W-1:0] seq_cnt;
    logic             load;
    logic             is_halt;

    // flush wins over stall and over a halt
    assign load      = flush || (!stall && !halted);
    // on flush the target word is read straight away
    assign imem_addr = flush ? jump_target : pc;
    assign is_halt   = op_of(imem_data) == OP_HALT;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            seq_cnt    <= '0;
            f_valid    <= 1'b0;
            fetch_fire <= 1'b0;
            halted     <= 1'b0;
        end else begin
            fetch_fire <= load;
            if (load) begin
                f_valid <= 1'b1;
                seq_cnt <= seq_cnt + 1'b1;
                // a redirect can clear a halt picked up on the wrong path
                halted  <= is_halt;
                // pc parks on a halt so no word past it is requested
                pc      <= is_halt ? imem_addr : imem_addr + 1'b1;
            end else if (!stall) begin
                // halted, last word moves on and fetch goes empty
                f_valid <= 1'b0;
            end
        end
    end

    // output register payload, tag taken at latch time
    always_ff @(posedge clk) begin
        if (load) begin
            f_pc      <= imem_addr;
            f_instr   <= imem_data;
            fetch_seq <= seq_cnt;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none

module decode_stage
    import pipe_pkg::*, trace_pkg::*;
#(
    parameter int SEQ_W = seq_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               f_valid,
    input  logic [pc_w-1:0]    f_pc,
    input  logic [instr_w-1:0] f_instr,
    input  logic [SEQ_W-1:0]   f_seq,
    input  logic               flush,
    input  logic               wb_we,
    input  logic [reg_aw-1:0]  wb_rd,
    input  logic [data_w-1:0]  wb_data,
    input  logic               x_valid,
    input  logic [instr_w-1:0] x_instr,
    input  logic               m_valid,
    input  logic [instr_w-1:0] m_instr,
    output logic               stall,
    output logic               d_valid,
    output logic [pc_w-1:0]    d_pc,
    output logic [instr_w-1:0] d_instr,
    output logic [SEQ_W-1:0]   d_seq,
    output logic [data_w-1:0]  d_a,
    output logic [data_w-1:0]  d_b
);

    logic [data_w-1:0]  rf [reg_count];
    logic [instr_w-1:0] src;
    logic [reg_aw-1:0]  a_sel;
    logic [reg_aw-1:0]  b_sel;
    logic [data_w-1:0]  a_rd;
    logic [data_w-1:0]  b_rd;
    logic               x_hit;
    logic               m_hit;
    logic               wb_hit;

    // ADD reads rd and rs, ADDI and STORE read rs
    function automatic logic reads_reg(input logic [instr_w-1:0] instr,
                                       input logic [reg_aw-1:0]  r);
        opcode_t op;
        op = op_of(instr);
        return (op == OP_ADD && rd_of(instr) == r) ||
               (op inside {OP_ADD, OP_ADDI, OP_STORE} && rs_of(instr) == r);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // dependency check against writes still in flight

    assign x_hit  = x_valid && writes_reg(op_of(x_instr)) && reads_reg(d_instr, rd_of(x_instr));
    assign m_hit  = m_valid && writes_reg(op_of(m_instr)) && reads_reg(d_instr, rd_of(m_instr));
    assign wb_hit = wb_we && reads_reg(d_instr, wb_rd);
    assign stall  = d_valid && (x_hit || m_hit || wb_hit);

    // a stalled instruction rereads its own operands
    assign src   = stall ? d_instr : f_instr;
    assign a_sel = rd_of(src);
    assign b_sel = rs_of(src);
    // write-through from writeback
    assign a_rd  = (wb_we && wb_rd == a_sel) ? wb_data : rf[a_sel];
    assign b_rd  = (wb_we && wb_rd == b_sel) ? wb_data : rf[b_sel];

    // architectural registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            rf <= '{default: '0};
        end else if (wb_we) begin
            rf[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= f_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_pc    <= f_pc;
            d_instr <= f_instr;
            d_seq   <= f_seq;
        end
        d_a <= a_rd;
        d_b <= b_rd;
    end

    // the producer drains through execute, memory and writeback in three cycles
    assert property (@(posedge clk) disable iff (rst)
        (stall && $past(stall) && $past(stall, 2)) |=> !stall);

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`default_nettype none

module execute_stage
    import pipe_pkg::*, trace_pkg::*;
#(
    parameter int SEQ_W = seq_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               d_valid,
    input  logic [pc_w-1:0]    d_pc,
    input  logic [instr_w-1:0] d_instr,
    input  logic [SEQ_W-1:0]   d_seq,
    input  logic [data_w-1:0]  d_a,
    input  logic [data_w-1:0]  d_b,
    input  logic               stall,
    output logic               x_valid,
    output logic [pc_w-1:0]    x_pc,
    output logic [instr_w-1:0] x_instr,
    output logic [SEQ_W-1:0]   x_seq,
    output logic [data_w-1:0]  x_result,
    output logic [data_w-1:0]  x_store_data,
    output logic               flush,
    output logic [pc_w-1:0]    jump_target
);

    logic [data_w-1:0] sum;

    // ADD is rd + rs, ADDI is rs + imm
    assign sum = ((op_of(d_instr) == OP_ADD) ? d_a : imm_of(d_instr)) + d_b;

    // stall and flush both leave a bubble behind
    always_ff @(posedge clk) begin
        if (rst) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= d_valid && !stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        x_pc         <= d_pc;
        x_instr      <= d_instr;
        x_seq        <= d_seq;
        x_result     <= sum;
        x_store_data <= d_b;
    end

    // jump resolves here and targets the imm field
    assign flush       = x_valid && op_of(x_instr) == OP_JMP;
    assign jump_target = pc_w'(imm_of(x_instr));

    // one cycle after a jump both decode and execute are empty, so flush cannot repeat
    assert property (@(posedge clk) disable iff (rst) flush |=> !x_valid && !d_valid);

endmodule

`default_nettype wire

//--- src/memory_wb_stage.sv
`default_nettype none

module memory_wb_stage
    import pipe_pkg::*, trace_pkg::*;
#(
    parameter int SEQ_W = seq_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               x_valid,
    input  logic [pc_w-1:0]    x_pc,
    input  logic [instr_w-1:0] x_instr,
    input  logic [SEQ_W-1:0]   x_seq,
    input  logic [data_w-1:0]  x_result,
    input  logic [data_w-1:0]  x_store_data,
    output logic               m_valid,
    output logic [instr_w-1:0] m_instr,
    output logic [SEQ_W-1:0]   m_seq,
    output logic               wb_valid,
    output logic [pc_w-1:0]    wb_pc,
    output logic [SEQ_W-1:0]   wb_seq,
    output logic               wb_we,
    output logic [reg_aw-1:0]  wb_rd,
    output logic [data_w-1:0]  wb_data
);

    logic [data_w-1:0]  dmem [dmem_words];
    logic [dmem_aw-1:0] addr;
    logic [pc_w-1:0]    m_pc;
    logic [data_w-1:0]  m_data;

    assign addr = dmem_addr_of(x_instr);

    always_ff @(posedge clk) begin
        if (x_valid && op_of(x_instr) == OP_STORE) begin
            dmem[addr] <= x_store_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory register

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= x_valid;
        end
    end

    // load data replaces the adder result
    always_ff @(posedge clk) begin
        m_pc    <= x_pc;
        m_instr <= x_instr;
        m_seq   <= x_seq;
        m_data  <= (op_of(x_instr) == OP_LOAD) ? dmem[addr] : x_result;
    end

    //////////////////////////////////////////////////////////////////////
    // writeback register, also the retirement point

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= m_valid;
            wb_we    <= m_valid && writes_reg(op_of(m_instr));
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= m_pc;
        wb_seq  <= m_seq;
        wb_rd   <= rd_of(m_instr);
        wb_data <= m_data;
    end

endmodule

`default_nettype wire

//--- src/stage_tracker.sv
`default_nettype none

module stage_tracker
    import trace_pkg::*;
#(
    parameter int TRACE_DEPTH = trace_depth,
    parameter int SEQ_W       = seq_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_fire,
    input  logic [SEQ_W-1:0]   fetch_seq,
    input  logic               d_valid,
    input  logic [SEQ_W-1:0]   d_seq,
    input  logic               x_valid,
    input  logic [SEQ_W-1:0]   x_seq,
    input  logic               m_valid,
    input  logic [SEQ_W-1:0]   m_seq,
    input  logic               wb_valid,
    input  logic [SEQ_W-1:0]   wb_seq,
    output logic               retire_valid,
    output logic [SEQ_W-1:0]   retire_seq,
    output logic [stamp_w-1:0] retire_fetch_cycle,
    output logic [stamp_w-1:0] retire_decode_cycle,
    output logic [stamp_w-1:0] retire_execute_cycle,
    output logic [stamp_w-1:0] retire_memory_cycle,
    output logic [stamp_w-1:0] retire_wb_cycle
);

    localparam int row_w = $clog2(TRACE_DEPTH);

    logic [stamp_w-1:0] cycle;
    // one column per stage, rows indexed by tag modulo depth
    logic [stamp_w-1:0] fetch_tab [TRACE_DEPTH];
    logic [stamp_w-1:0] dec_tab   [TRACE_DEPTH];
    logic [stamp_w-1:0] exe_tab   [TRACE_DEPTH];
    logic [stamp_w-1:0] mem_tab   [TRACE_DEPTH];
    logic [row_w-1:0]   wb_row;
    logic [SEQ_W-1:0]   last_seq;
    logic [SEQ_W-1:0]   seq_step;
    logic               seen;

    function automatic logic [row_w-1:0] row_of(input logic [SEQ_W-1:0] seq);
        return row_w'(seq);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stamp table writes

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            fetch_tab[row_of(fetch_seq)] <= cycle;
        end
        // rewritten each stall cycle, keeps the last one
        if (d_valid) begin
            dec_tab[row_of(d_seq)] <= cycle;
        end
        if (x_valid) begin
            exe_tab[row_of(x_seq)] <= cycle;
        end
        if (m_valid) begin
            mem_tab[row_of(m_seq)] <= cycle;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // retirement record

    assign wb_row               = row_of(wb_seq);
    assign retire_valid         = wb_valid;
    assign retire_seq           = wb_seq;
    assign retire_fetch_cycle   = fetch_tab[wb_row];
    assign retire_decode_cycle  = dec_tab[wb_row];
    assign retire_execute_cycle = exe_tab[wb_row];
    assign retire_memory_cycle  = mem_tab[wb_row];
    // wb stamp is the retire cycle itself
    assign retire_wb_cycle      = cycle;

    // previous retired tag, for the order check
    always_ff @(posedge clk) begin
        if (rst) begin
            seen     <= 1'b0;
            last_seq <= '0;
        end else if (retire_valid) begin
            seen     <= 1'b1;
            last_seq <= retire_seq;
        end
    end

    assign seq_step = retire_seq - last_seq;

    assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_fetch_cycle < retire_decode_cycle &&
                         retire_decode_cycle < retire_execute_cycle &&
                         retire_execute_cycle < retire_memory_cycle &&
                         retire_memory_cycle < retire_wb_cycle);

    // tags move forward only, flushed ones may be skipped
    assert property (@(posedge clk) disable iff (rst)
        retire_valid && seen |-> seq_step != '0 && !seq_step[SEQ_W-1]);

endmodule

`default_nettype wire

//--- src/pipe_top.sv
`default_nettype none

module pipe_top
    import pipe_pkg::*, trace_pkg::*;
#(
    parameter int TRACE_DEPTH = trace_depth,
    parameter int SEQ_W       = seq_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [instr_w-1:0] imem_data,
    output logic [pc_w-1:0]    imem_addr,
    output logic               halted,
    output logic               retire_valid,
    output logic [pc_w-1:0]    retire_pc,
    output logic [SEQ_W-1:0]   retire_seq,
    output logic               retire_we,
    output logic [reg_aw-1:0]  retire_rd,
    output logic [data_w-1:0]  retire_data,
    output logic [stamp_w-1:0] retire_fetch_cycle,
    output logic [stamp_w-1:0] retire_decode_cycle,
    output logic [stamp_w-1:0] retire_execute_cycle,
    output logic [stamp_w-1:0] retire_memory_cycle,
    output logic [stamp_w-1:0] retire_wb_cycle
);

    // hazard and redirect
    logic               stall;
    logic               flush;
    logic [pc_w-1:0]    jump_target;

    // fetch register
    logic               f_valid;
    logic [pc_w-1:0]    f_pc;
    logic [instr_w-1:0] f_instr;
    logic               fetch_fire;
    logic [SEQ_W-1:0]   fetch_seq;

    // decode register
    logic               d_valid;
    logic [pc_w-1:0]    d_pc;
    logic [instr_w-1:0] d_instr;
    logic [SEQ_W-1:0]   d_seq;
    logic [data_w-1:0]  d_a;
    logic [data_w-1:0]  d_b;

    // execute register
    logic               x_valid;
    logic [pc_w-1:0]    x_pc;
    logic [instr_w-1:0] x_instr;
    logic [SEQ_W-1:0]   x_seq;
    logic [data_w-1:0]  x_result;
    logic [data_w-1:0]  x_store_data;

    // memory and writeback registers
    logic               m_valid;
    logic [instr_w-1:0] m_instr;
    logic [SEQ_W-1:0]   m_seq;
    logic               wb_valid;
    logic [pc_w-1:0]    wb_pc;
    logic [SEQ_W-1:0]   wb_seq;
    logic               wb_we;
    logic [reg_aw-1:0]  wb_rd;
    logic [data_w-1:0]  wb_data;

    fetch_stage #(.SEQ_W(SEQ_W)) u_fetch (
        .clk, .rst, .stall, .flush, .jump_target, .imem_data, .imem_addr,
        .f_valid, .f_pc, .f_instr, .fetch_fire, .fetch_seq, .halted
    );

    // the fetch tag rides along as f_seq
    decode_stage #(.SEQ_W(SEQ_W)) u_decode (
        .clk, .rst, .f_valid, .f_pc, .f_instr, .f_seq(fetch_seq), .flush,
        .wb_we, .wb_rd, .wb_data, .x_valid, .x_instr, .m_valid, .m_instr,
        .stall, .d_valid, .d_pc, .d_instr, .d_seq, .d_a, .d_b
    );

    execute_stage #(.SEQ_W(SEQ_W)) u_execute (
        .clk, .rst, .d_valid, .d_pc, .d_instr, .d_seq, .d_a, .d_b, .stall,
        .x_valid, .x_pc, .x_instr, .x_seq, .x_result, .x_store_data,
        .flush, .jump_target
    );

    memory_wb_stage #(.SEQ_W(SEQ_W)) u_memory_wb (
        .clk, .rst, .x_valid, .x_pc, .x_instr, .x_seq, .x_result, .x_store_data,
        .m_valid, .m_instr, .m_seq, .wb_valid, .wb_pc, .wb_seq,
        .wb_we, .wb_rd, .wb_data
    );

    stage_tracker #(.TRACE_DEPTH(TRACE_DEPTH), .SEQ_W(SEQ_W)) u_tracker (
        .clk, .rst, .fetch_fire, .fetch_seq, .d_valid, .d_seq, .x_valid, .x_seq,
        .m_valid, .m_seq, .wb_valid, .wb_seq, .retire_valid, .retire_seq,
        .retire_fetch_cycle, .retire_decode_cycle, .retire_execute_cycle,
        .retire_memory_cycle, .retire_wb_cycle
    );

    // architectural side of the retirement record
    assign retire_pc   = wb_pc;
    assign retire_we   = wb_we;
    assign retire_rd   = wb_rd;
    assign retire_data = wb_data;

endmodule

`default_nettype wire

//--- testbench/tb_pipe_top.sv
`default_nettype none

module tb_pipe_top
    import pipe_pkg::*, trace_pkg::*;
();

    localparam int n_tests  = 4;
    localparam int prog_len = 8;
    localparam int max_ret  = 8;
    // every instruction slot may take 8 cycles, plus reset and quiet time
    localparam int timeout_cycles = n_tests * (prog_len * 8 + 10);

    logic               clk;
    logic               rst;
    logic [instr_w-1:0] imem_data;
    logic [pc_w-1:0]    imem_addr;
    logic               halted;
    logic               retire_valid;
    logic [pc_w-1:0]    retire_pc;
    logic [seq_w-1:0]   retire_seq;
    logic               retire_we;
    logic [reg_aw-1:0]  retire_rd;
    logic [data_w-1:0]  retire_data;
    logic [stamp_w-1:0] retire_fetch_cycle;
    logic [stamp_w-1:0] retire_decode_cycle;
    logic [stamp_w-1:0] retire_execute_cycle;
    logic [stamp_w-1:0] retire_memory_cycle;
    logic [stamp_w-1:0] retire_wb_cycle;

    // program rows, filler after HALT is random
    logic [instr_w-1:0] prog [n_tests][prog_len];
    int    halt_idx  [n_tests];
    string test_name [n_tests];
    // expected retirement records, one column per field
    int    exp_count [n_tests];
    int    exp_pc    [n_tests][max_ret];
    int    exp_seq   [n_tests][max_ret];
    int    exp_we    [n_tests][max_ret];
    int    exp_rd    [n_tests][max_ret];
    int    exp_data  [n_tests][max_ret];
    int    exp_stall [n_tests][max_ret];

    int cur_test;
    int errors;
    int run_cycles = 0;

    pipe_top u_pipe_top (
        .clk, .rst, .imem_data, .imem_addr, .halted, .retire_valid, .retire_pc,
        .retire_seq, .retire_we, .retire_rd, .retire_data, .retire_fetch_cycle,
        .retire_decode_cycle, .retire_execute_cycle, .retire_memory_cycle,
        .retire_wb_cycle
    );

    always #5 clk = ~clk;

    // instruction memory model, words past the row read as NOP
    always_comb begin
        if (int'(imem_addr) < prog_len) begin
            imem_data = prog[cur_test][imem_addr[2:0]];
        end else begin
            imem_data = '0;
        end
    end

    // run length guard
    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles >= timeout_cycles) begin
            $display("timeout: HALT did not retire within %0d cycles", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // fetch must never reach past the HALT word
    always @(negedge clk) begin
        if (!rst) begin
            assert (int'(imem_addr) <= halt_idx[cur_test]) else begin
                $display("fetch requested filler word at imem_addr 0x%0h", imem_addr);
                errors++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // program table

    // fields: op 15..12, rd 11..10, rs 9..8, imm 7..0
    function automatic logic [instr_w-1:0] encode(input opcode_t op, input int rd,
                                                  input int rs, input int imm);
        return {op, 2'(rd), 2'(rs), 8'(imm)};
    endfunction

    task automatic expect_retire(input int t, input int pc, input int seq, input int we,
                                 input int rd, input int data, input int stall);
        exp_pc[t][exp_count[t]]    = pc;
        exp_seq[t][exp_count[t]]   = seq;
        exp_we[t][exp_count[t]]    = we;
        exp_rd[t][exp_count[t]]    = rd;
        exp_data[t][exp_count[t]]  = data;
        exp_stall[t][exp_count[t]] = stall;
        exp_count[t]++;
    endtask

    task automatic build_table();
        test_name[0] = "independent addi";
        prog[0] = '{encode(OP_ADDI, 1, 0, 'h05), encode(OP_ADDI, 2, 0, 'h11),
                    encode(OP_ADDI, 3, 0, 'h7f), encode(OP_ADDI, 2, 0, 'ha0),
                    encode(OP_HALT, 0, 0, 0), '0, '0, '0};
        test_name[1] = "add after addi";
        prog[1] = '{encode(OP_ADDI, 1, 0, 'h05), encode(OP_ADD, 1, 1, 0),
                    encode(OP_ADDI, 2, 0, 'h30), encode(OP_HALT, 0, 0, 0),
                    '0, '0, '0, '0};
        test_name[2] = "store then load";
        prog[2] = '{encode(OP_ADDI, 1, 0, 'h5a), encode(OP_STORE, 0, 1, 'h03),
                    encode(OP_LOAD, 2, 0, 'h03), encode(OP_ADD, 2, 1, 0),
                    encode(OP_HALT, 0, 0, 0), '0, '0, '0};
        test_name[3] = "jump";
        prog[3] = '{encode(OP_ADDI, 1, 0, 'h07), encode(OP_JMP, 0, 0, 'h04),
                    encode(OP_ADDI, 1, 0, 'hee), encode(OP_ADDI, 2, 0, 'hdd),
                    encode(OP_ADDI, 3, 1, 'h01), encode(OP_HALT, 0, 0, 0), '0, '0};
        for (int t = 0; t < n_tests; t++) begin
            exp_count[t] = 0;
        end
        // test, pc, seq, we, rd, data, stall cycles
        expect_retire(0, 0, 0, 1, 1, 'h05, 0);
        expect_retire(0, 1, 1, 1, 2, 'h11, 0);
        expect_retire(0, 2, 2, 1, 3, 'h7f, 0);
        expect_retire(0, 3, 3, 1, 2, 'ha0, 0);
        expect_retire(0, 4, 4, 0, 0, 0, 0);
        // add waits out the addi in execute, memory and writeback
        expect_retire(1, 0, 0, 1, 1, 'h05, 0);
        expect_retire(1, 1, 1, 1, 1, 'h0a, 3);
        expect_retire(1, 2, 2, 1, 2, 'h30, 3);
        expect_retire(1, 3, 3, 0, 0, 0, 0);
        expect_retire(2, 0, 0, 1, 1, 'h5a, 0);
        expect_retire(2, 1, 1, 0, 0, 0, 3);
        expect_retire(2, 2, 2, 1, 2, 'h5a, 3);
        expect_retire(2, 3, 3, 1, 2, 'hb4, 3);
        expect_retire(2, 4, 4, 0, 0, 0, 3);
        // pc 2 and 3 are flushed, their tags 2 and 3 never retire
        expect_retire(3, 0, 0, 1, 1, 'h07, 0);
        expect_retire(3, 1, 1, 0, 0, 0, 0);
        expect_retire(3, 4, 4, 1, 3, 'h08, 0);
        expect_retire(3, 5, 5, 0, 0, 0, 0);
        // first HALT ends the row, random words behind it
        for (int t = 0; t < n_tests; t++) begin
            halt_idx[t] = prog_len - 1;
            for (int i = prog_len - 1; i >= 0; i--) begin
                if (prog[t][i][15:12] == OP_HALT) begin
                    halt_idx[t] = i;
                end
            end
            for (int i = halt_idx[t] + 1; i < prog_len; i++) begin
                prog[t][i] = instr_w'($urandom);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // checks

    task automatic check_value(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_record(input int t, input int n);
        int stall;
        stall = exp_stall[t][n];
        check_value("retire_pc", int'(retire_pc), exp_pc[t][n]);
        check_value("retire_seq", int'(retire_seq), exp_seq[t][n]);
        check_value("retire_we", int'(retire_we), exp_we[t][n]);
        if (exp_we[t][n] != 0) begin
            check_value("retire_rd", int'(retire_rd), exp_rd[t][n]);
            check_value("retire_data", int'(retire_data), exp_data[t][n]);
        end
        // decode stamp moves with each stall cycle, later stages follow one apart
        check_value("retire_decode_cycle - retire_fetch_cycle",
                    int'(retire_decode_cycle) - int'(retire_fetch_cycle), 1 + stall);
        check_value("retire_execute_cycle - retire_decode_cycle",
                    int'(retire_execute_cycle) - int'(retire_decode_cycle), 1);
        check_value("retire_memory_cycle - retire_execute_cycle",
                    int'(retire_memory_cycle) - int'(retire_execute_cycle), 1);
        check_value("retire_wb_cycle - retire_memory_cycle",
                    int'(retire_wb_cycle) - int'(retire_memory_cycle), 1);
    endtask

    task automatic apply_reset(input int t);
        @(posedge clk);
        rst      <= 1'b1;
        cur_test <= t;
        repeat (4) @(posedge clk);
        rst      <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // test loop

    initial begin
        int      n;
        int      start_errors;
        int      passed;
        bit      done;
        int      prev_fetch;
        opcode_t prev_op;
        opcode_t op;
        clk      = 1'b0;
        rst      = 1'b1;
        cur_test = 0;
        errors   = 0;
        passed   = 0;
        void'($urandom(59));
        build_table();
        for (int t = 0; t < n_tests; t++) begin
            start_errors = errors;
            apply_reset(t);
            n          = 0;
            done       = 1'b0;
            prev_op    = OP_NOP;
            prev_fetch = 0;
            // outputs read mid-cycle, away from the clock edge
            while (!done) begin
                @(negedge clk);
                if (retire_valid) begin
                    op = opcode_t'(prog[t][retire_pc[2:0]][15:12]);
                    if (n >= exp_count[t]) begin
                        assert (0) else begin
                            $display("retirement at pc 0x%0h beyond the expected count",
                                     retire_pc);
                            errors++;
                        end
                        done = 1'b1;
                    end else begin
                        check_record(t, n);
                    end
                    // jump target is latched three cycles after the jump
                    if (prev_op == OP_JMP) begin
                        check_value("retire_fetch_cycle after jump - jump fetch",
                                    int'(retire_fetch_cycle) - prev_fetch, 3);
                    end
                    if (op == OP_HALT) begin
                        done = 1'b1;
                        check_value("halted", int'(halted), 1);
                    end
                    prev_op    = op;
                    prev_fetch = int'(retire_fetch_cycle);
                    n++;
                end
            end
            check_value("retire count", n, exp_count[t]);
            // nothing may retire once HALT is out
            repeat (6) begin
                @(negedge clk);
                assert (!retire_valid) else begin
                    $display("retirement after HALT at pc 0x%0h", retire_pc);
                    errors++;
                end
            end
            check_value("halted", int'(halted), 1);
            if (errors == start_errors) begin
                passed++;
            end
            $display("test %0d (%s): %0d retirements, %s", t, test_name[t], n,
                     (errors == start_errors) ? "ok" : "FAIL");
        end
        $display("%0d of %0d tests passed, %0d errors", passed, n_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/pipe_pkg.sv
src/trace_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_wb_stage.sv
src/stage_tracker.sv
src/pipe_top.sv
testbench/tb_pipe_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_pipe_top -f sources.f -Mdir obj_dir -o sim_pipe \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_pipe > sim.log 2>&1 \
    || { cat sim.log; echo "simulation ended with an error status"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
